// File: hdl/bpred_pkg.sv
`default_nettype none

`include "bpred_defines.svh"

package bpred_pkg;

	// stored perceptron weight, two's complement
	typedef logic signed [`BPRED_WEIGHT_W-1:0] weight_t;

	// one lane's contribution, wide enough for the negated high bits
	typedef logic signed [`BPRED_HOB_W:0] vote_t;

	// one vote per history position
	typedef vote_t [`BPRED_GHR_LEN-1:0] vote_vec_t;

	// global history, bit 0 is the newest outcome
	typedef logic [`BPRED_GHR_LEN-1:0] ghr_t;

	// perceptron table index
	typedef logic [`BPRED_TABLE_IDX_W-1:0] tbl_idx_t;

	// predecoded target select field
	typedef enum logic [1:0] {
		TGT_SEQ   = 2'b00,
		// return, no stack here so it falls back to pc+4
		TGT_RET   = 2'b01,
		TGT_IMM16 = 2'b10,
		TGT_IMM26 = 2'b11
	} target_sel_e;

endpackage

`default_nettype wire

// File: hdl/bpred_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module bpred_top import bpred_pkg::*; (
	input  wire logic                          clk,
	input  wire logic                          reset,
	// instruction memory preload
	input  wire logic                          imem_wren,
	input  wire logic [`BPRED_IMEM_ADDR_W-1:0] imem_addr,
	input  wire logic [`BPRED_XLEN-1:0]        imem_data,
	// redirect from execute
	input  wire logic                          redirect,
	input  wire logic [`BPRED_XLEN-1:0]        redirect_pc,
	// resolved branch for training
	input  wire logic                          update,
	input  wire logic [`BPRED_XLEN-1:0]        update_pc,
	input  wire logic                          update_dir,
	// fetch side
	output logic      [`BPRED_XLEN-1:0]        fetch_pc,
	output logic      [`BPRED_XLEN-1:0]        fetch_insn,
	output logic                               pred_dir
);

	logic [`BPRED_XLEN-1:0] next_pc;
	logic perceptron_taken;
	vote_vec_t votes;

	history_if hist ();

	// ========================================
	// fetch path
	// ========================================

	// read at next_pc so the word lines up with fetch_pc
	insn_mem u_insn_mem (
		.clk   (clk),
		.wren  (imem_wren),
		.waddr (imem_addr),
		.wdata (imem_data),
		.raddr (next_pc[`BPRED_IMEM_ADDR_W+1:2]),
		.rdata (fetch_insn)
	);

	fetch_unit u_fetch_unit (
		.clk              (clk),
		.reset            (reset),
		.insn             (fetch_insn),
		.perceptron_taken (perceptron_taken),
		.redirect         (redirect),
		.redirect_pc      (redirect_pc),
		.fetch_pc         (fetch_pc),
		.next_pc          (next_pc),
		.pred_dir         (pred_dir)
	);

	// ========================================
	// direction predictor
	// ========================================

	history_register u_history_register (
		.clk        (clk),
		.reset      (reset),
		.next_pc    (next_pc),
		.update     (update),
		.update_pc  (update_pc),
		.update_dir (update_dir),
		.hist       (hist.source)
	);

	// one weight column per history bit
	for (genvar i = 0; i < `BPRED_GHR_LEN; i++) begin : g_lane
		perceptron_lane #(
			.LANE (i)
		) u_lane (
			.clk   (clk),
			.reset (reset),
			.hist  (hist.lane),
			.vote  (votes[i])
		);
	end

	perceptron_sum u_perceptron_sum (
		.votes            (votes),
		.perceptron_taken (perceptron_taken)
	);

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module fetch_unit import bpred_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   reset,
	// word fetched at fetch_pc
	input  wire logic [`BPRED_XLEN-1:0] insn,
	input  wire logic                   perceptron_taken,
	// external redirect from execute
	input  wire logic                   redirect,
	input  wire logic [`BPRED_XLEN-1:0] redirect_pc,
	output logic      [`BPRED_XLEN-1:0] fetch_pc,
	output logic      [`BPRED_XLEN-1:0] next_pc,
	output logic                        pred_dir
);

	target_sel_e sel_field;
	target_sel_e eff_sel;
	logic uncond;

	logic [`BPRED_XLEN-1:0] pc_plus4;
	logic [`BPRED_XLEN-1:0] imm16_ext;
	logic [`BPRED_XLEN-1:0] imm16_sum;
	logic [`BPRED_XLEN-1:0] target_imm16;
	logic [`BPRED_XLEN-1:0] target_imm26;

	// ========================================
	// predecode
	// ========================================

	// select and unconditional flag sit in the top bits
	assign sel_field = target_sel_e'(insn[`BPRED_SEL_MSB:`BPRED_SEL_LSB]);
	assign uncond = insn[`BPRED_UNCOND_BIT];

	// unconditional words always go, others follow the perceptron
	assign pred_dir = uncond | perceptron_taken;

	// not-taken collapses any select to sequential
	assign eff_sel = target_sel_e'(sel_field & {2{pred_dir}});

	// ========================================
	// targets
	// ========================================

	assign pc_plus4 = fetch_pc + `BPRED_XLEN'd4;

	// sign-extend the 16-bit offset
	assign imm16_ext = {
		{(`BPRED_XLEN-16){insn[`BPRED_IMM16_MSB]}},
		insn[`BPRED_IMM16_MSB:`BPRED_IMM16_LSB]
	};
	assign imm16_sum = pc_plus4 + imm16_ext;
	// word aligned
	assign target_imm16 = {imm16_sum[`BPRED_XLEN-1:2], 2'b00};

	// region bits from the current pc, then the field, then alignment
	assign target_imm26 = {
		fetch_pc[`BPRED_XLEN-1:`BPRED_IMM26_MSB+3],
		insn[`BPRED_IMM26_MSB:0],
		2'b00
	};

	// ========================================
	// next pc
	// ========================================

	always_comb begin
		if (reset) begin
			// memory and tables are read at 0 while in reset
			next_pc = '0;
		end else if (redirect) begin
			// redirect beats any prediction
			next_pc = redirect_pc;
		end else begin
			case (eff_sel)
				TGT_SEQ:   next_pc = pc_plus4;
				TGT_RET:   next_pc = pc_plus4;
				TGT_IMM16: next_pc = target_imm16;
				TGT_IMM26: next_pc = target_imm26;
				default:   next_pc = pc_plus4;
			endcase
		end
	end

	// pc register
	always_ff @(posedge clk) begin
		if (reset) begin
			fetch_pc <= '0;
		end else begin
			fetch_pc <= next_pc;
		end
	end

endmodule

`default_nettype wire

// File: hdl/history_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

interface history_if import bpred_pkg::*; ();

	// global history, pre-shift value during a strobe cycle
	ghr_t ghr;
	// index of the pc being looked up
	tbl_idx_t fetch_idx;
	// index of the branch being trained
	tbl_idx_t upd_idx;
	// single-cycle training strobe, no back-pressure
	logic upd_strobe;
	// resolved direction, 1 is taken
	logic upd_dir;

	// history module drives everything
	modport source (
		output ghr,
		output fetch_idx,
		output upd_idx,
		output upd_strobe,
		output upd_dir
	);

	// each lane only listens
	modport lane (
		input ghr,
		input fetch_idx,
		input upd_idx,
		input upd_strobe,
		input upd_dir
	);

endinterface

`default_nettype wire

// File: hdl/history_register.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module history_register import bpred_pkg::*; (
	input  wire logic                   clk,
	input  wire logic                   reset,
	// lookup address for the next fetch
	input  wire logic [`BPRED_XLEN-1:0] next_pc,
	// training request from execute
	input  wire logic                   update,
	input  wire logic [`BPRED_XLEN-1:0] update_pc,
	input  wire logic                   update_dir,
	history_if.source                   hist
);

	ghr_t ghr_q;

	// ========================================
	// global history
	// ========================================

	// newest outcome enters at bit 0
	always_ff @(posedge clk) begin
		if (reset) begin
			ghr_q <= '0;
		end else if (update) begin
			ghr_q <= {ghr_q[`BPRED_GHR_LEN-2:0], update_dir};
		end
	end

	// lanes train against this value at the shift edge
	assign hist.ghr = ghr_q;

	// ========================================
	// table indices
	// ========================================

	// word-aligned pc, drop the low two bits
	assign hist.fetch_idx = next_pc[`BPRED_TABLE_IDX_W+1:2];
	assign hist.upd_idx = update_pc[`BPRED_TABLE_IDX_W+1:2];

	// training strobe and outcome go straight to every lane
	assign hist.upd_strobe = update;
	assign hist.upd_dir = update_dir;

endmodule

`default_nettype wire

// File: hdl/insn_mem.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module insn_mem (
	input  wire logic                          clk,
	// preload port
	input  wire logic                          wren,
	input  wire logic [`BPRED_IMEM_ADDR_W-1:0] waddr,
	input  wire logic [`BPRED_XLEN-1:0]        wdata,
	// fetch port, word address
	input  wire logic [`BPRED_IMEM_ADDR_W-1:0] raddr,
	output logic      [`BPRED_XLEN-1:0]        rdata
);

	// word storage
	logic [`BPRED_XLEN-1:0] mem [`BPRED_IMEM_DEPTH];

	// ========================================
	// write and registered read
	// ========================================

	// one block for both ports so a colliding read sees the old word
	always_ff @(posedge clk) begin
		if (wren) begin
			mem[waddr] <= wdata;
		end
		// one cycle read latency
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

// File: hdl/perceptron_lane.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module perceptron_lane import bpred_pkg::*; #(
	// history position handled by this lane
	parameter int LANE = 0
) (
	input  wire logic clk,
	input  wire logic reset,
	history_if.lane   hist,
	output vote_t     vote
);

	// saturation limits of a weight
	localparam weight_t W_MAX = weight_t'({1'b0, {(`BPRED_WEIGHT_W-1){1'b1}}});
	localparam weight_t W_MIN = weight_t'({1'b1, {(`BPRED_WEIGHT_W-1){1'b0}}});

	// one weight per table entry for this history bit
	weight_t weights [`BPRED_TABLE_ENTRIES];

	weight_t rd_weight;
	weight_t upd_weight;
	weight_t next_weight;
	logic agree;
	logic signed [`BPRED_HOB_W-1:0] hob;

	// ========================================
	// lookup and vote
	// ========================================

	// only the high bits take part in the vote
	assign hob = rd_weight[`BPRED_WEIGHT_W-1 -: `BPRED_HOB_W];

	// history 1 adds the weight, history 0 subtracts it
	assign vote = hist.ghr[LANE] ? vote_t'(hob) : -vote_t'(hob);

	// ========================================
	// training
	// ========================================

	// old entry read straight from the column
	assign upd_weight = weights[hist.upd_idx];
	assign agree = (hist.upd_dir == hist.ghr[LANE]);

	// +1 on agreement, -1 otherwise, clamp at the ends
	always_comb begin
		next_weight = upd_weight;
		if (agree) begin
			if (upd_weight != W_MAX) begin
				next_weight = upd_weight + weight_t'(1);
			end
		end else begin
			if (upd_weight != W_MIN) begin
				next_weight = upd_weight - weight_t'(1);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			// zero weights give a taken prediction
			for (int e = 0; e < `BPRED_TABLE_ENTRIES; e++) begin
				weights[e] <= '0;
			end
			rd_weight <= '0;
		end else begin
			// same-index write is seen one lookup later
			rd_weight <= weights[hist.fetch_idx];
			if (hist.upd_strobe) begin
				weights[hist.upd_idx] <= next_weight;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/perceptron_sum.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module perceptron_sum import bpred_pkg::*; (
	input  wire vote_vec_t votes,
	output logic           perceptron_taken
);

	localparam int HALF = `BPRED_GHR_LEN / 2;

	logic signed [`BPRED_SUM_W-1:0] lvl1 [2];
	logic signed [`BPRED_SUM_W-1:0] sum;

	// ========================================
	// adder tree
	// ========================================

	// level 1 sums the lower and upper half of the lanes
	always_comb begin
		lvl1[0] = '0;
		lvl1[1] = '0;
		for (int i = 0; i < HALF; i++) begin
			// widen each vote before adding
			lvl1[0] = lvl1[0] + `BPRED_SUM_W'(vote_t'(votes[i]));
			lvl1[1] = lvl1[1] + `BPRED_SUM_W'(vote_t'(votes[i+HALF]));
		end
	end

	// level 2
	assign sum = lvl1[0] + lvl1[1];

	// zero or positive predicts taken
	assign perceptron_taken = ~sum[`BPRED_SUM_W-1];

endmodule

`default_nettype wire

// File: include/bpred_defines.svh
`ifndef BPRED_DEFINES_SVH
`define BPRED_DEFINES_SVH

// ========================================
// datapath widths
// ========================================

// address and instruction width
`define BPRED_XLEN 32

// global history length, also the lane count
`define BPRED_GHR_LEN 8

// stored weight width
`define BPRED_WEIGHT_W 8

// high weight bits that feed the vote
`define BPRED_HOB_W 3

// signed sum of all lane votes
`define BPRED_SUM_W 7

// ========================================
// table sizes
// ========================================

// perceptron table, indexed by pc[5:2]
`define BPRED_TABLE_ENTRIES 16
`define BPRED_TABLE_IDX_W 4

// instruction memory, word address is pc[9:2]
`define BPRED_IMEM_DEPTH 256
`define BPRED_IMEM_ADDR_W 8

// ========================================
// instruction fields
// ========================================

// 16-bit signed offset
`define BPRED_IMM16_LSB 6
`define BPRED_IMM16_MSB 21

// 26-bit absolute field starts at bit 0
`define BPRED_IMM26_MSB 25

// predecoded target select and unconditional flag
`define BPRED_SEL_MSB 31
`define BPRED_SEL_LSB 30
`define BPRED_UNCOND_BIT 29

`endif

// File: sim/bpred_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bpred_defines.svh"

module bpred_tb;

	// 8 ns clock
	localparam int CLK_HALF = 4;
	// weight limits and the shift that leaves only the high bits
	localparam int W_MAX = 2 ** (`BPRED_WEIGHT_W - 1) - 1;
	localparam int W_MIN = -(2 ** (`BPRED_WEIGHT_W - 1));
	localparam int HOB_SHIFT = `BPRED_WEIGHT_W - `BPRED_HOB_W;

	// one table row whose count repeats its stimulus and expected pc
	typedef struct packed {
		logic [3:0]  test;
		logic [7:0]  count;
		logic        pl_en;
		logic [7:0]  pl_addr;
		logic [31:0] pl_word;
		logic        redirect;
		logic [31:0] redirect_pc;
		logic        update;
		logic [31:0] update_pc;
		logic        update_dir;
		logic [31:0] exp_pc;
	} row_t;

	logic clk;
	logic reset;
	logic imem_wren;
	logic [`BPRED_IMEM_ADDR_W-1:0] imem_addr;
	logic [`BPRED_XLEN-1:0] imem_data;
	logic redirect;
	logic [`BPRED_XLEN-1:0] redirect_pc;
	logic update;
	logic [`BPRED_XLEN-1:0] update_pc;
	logic update_dir;
	logic [`BPRED_XLEN-1:0] fetch_pc;
	logic [`BPRED_XLEN-1:0] fetch_insn;
	logic pred_dir;

	row_t rows [$];
	// memory image of filler plus the table's words
	logic [31:0] image [`BPRED_IMEM_DEPTH];

	// reference predictor state
	int model_w [`BPRED_GHR_LEN][`BPRED_TABLE_ENTRIES];
	int lat_w [`BPRED_GHR_LEN];
	logic [`BPRED_GHR_LEN-1:0] model_ghr;
	// update driven last cycle that lands at the edge just passed
	logic pend_upd;
	logic pend_dir;
	logic [31:0] pend_pc;

	int seed;
	int cyc = 0;
	int n_checks;
	int n_errors;
	int test_checks;
	int test_errors;

	bpred_top u_dut (
		.clk         (clk),
		.reset       (reset),
		.imem_wren   (imem_wren),
		.imem_addr   (imem_addr),
		.imem_data   (imem_data),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.update      (update),
		.update_pc   (update_pc),
		.update_dir  (update_dir),
		.fetch_pc    (fetch_pc),
		.fetch_insn  (fetch_insn),
		.pred_dir    (pred_dir)
	);

	always #CLK_HALF clk = ~clk;

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	// ========================================
	// helpers
	// ========================================

	// polls in 1 ns steps and returns 1 ns after the n-th edge
	task automatic wait_cycles(input int n);
		int target;
		int waited;
		target = cyc + n;
		waited = 0;
		while (cyc < target && waited < n * 2 * CLK_HALF + 16) begin
			#1;
			waited++;
		end
		if (cyc < target) begin
			$display("timeout: clock did not advance by %0d cycles", n);
			$display(">>> FAIL");
			$finish;
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		n_checks++;
		test_checks++;
		if (got !== exp) begin
			n_errors++;
			test_errors++;
			$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// step toward agreement with each history bit and clamp before the shift
	task automatic model_train(input logic [31:0] pc, input logic dir);
		int idx;
		idx = pc[`BPRED_TABLE_IDX_W+1:2];
		for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
			if (dir == model_ghr[i]) begin
				if (model_w[i][idx] < W_MAX) begin
					model_w[i][idx]++;
				end
			end else if (model_w[i][idx] > W_MIN) begin
				model_w[i][idx]--;
			end
		end
		model_ghr = {model_ghr[`BPRED_GHR_LEN-2:0], dir};
	endtask

	function automatic logic model_pred(input logic [31:0] insn);
		int sum;
		int hob;
		sum = 0;
		for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
			// signed high bits of the weight
			hob = lat_w[i] >>> HOB_SHIFT;
			if (model_ghr[i]) begin
				sum = sum + hob;
			end else begin
				sum = sum - hob;
			end
		end
		return insn[`BPRED_UNCOND_BIT] | (sum >= 0);
	endfunction

	task automatic check_cycle(input logic [31:0] exp_pc);
		int idx;
		logic [31:0] exp_insn;
		idx = exp_pc[`BPRED_TABLE_IDX_W+1:2];
		// lookup at this edge saw the weights before a same-edge write
		for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
			lat_w[i] = model_w[i][idx];
		end
		if (pend_upd) begin
			model_train(pend_pc, pend_dir);
		end
		exp_insn = image[exp_pc[`BPRED_IMEM_ADDR_W+1:2]];
		check_value("fetch_pc", exp_pc, fetch_pc);
		check_value("fetch_insn", exp_insn, fetch_insn);
		check_value("pred_dir", {31'd0, model_pred(exp_insn)}, {31'd0, pred_dir});
	endtask

	task automatic drive_row(input row_t r);
		redirect = r.redirect;
		redirect_pc = r.redirect_pc;
		update = r.update;
		update_pc = r.update_pc;
		update_dir = r.update_dir;
		pend_upd = r.update;
		pend_pc = r.update_pc;
		pend_dir = r.update_dir;
	endtask

	task automatic add_row(input int test, input int count, input bit pl_en, input int pl_addr,
		input logic [31:0] pl_word, input bit redir, input logic [31:0] redir_pc,
		input bit upd, input logic [31:0] upd_pc, input bit upd_dir, input logic [31:0] exp_pc);
		row_t r;
		r = {4'(test), 8'(count), pl_en, 8'(pl_addr), pl_word, redir, redir_pc,
			upd, upd_pc, upd_dir, exp_pc};
		rows.push_back(r);
	endtask

	function automatic string test_title(input int t);
		case (t)
			1: return "sequential fetch";
			2: return "imm16 targets";
			3: return "imm26 and return select";
			4: return "redirect priority";
			5: return "perceptron training";
			6: return "weight saturation";
			default: return "taken history";
		endcase
	endfunction

	// ========================================
	// stimulus table
	// ========================================

	// test, count, pl_en, pl_addr, pl_word, redirect, redirect_pc,
	// update, update_pc, update_dir, expected fetch_pc
	task automatic build_table();
		add_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0000);
		add_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0004);
		add_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0008);
		add_row(1, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_000C);
		// imm16 offset +0x2e lands at 0x40 once the low bits drop
		add_row(1, 1, 1, 4, 32'hA000_0B80, 0, 0, 0, 0, 0, 32'h0000_0010);
		// imm16 -0x24 back to 0x20
		add_row(2, 1, 1, 16, 32'hA03F_F700, 0, 0, 0, 0, 0, 32'h0000_0040);
		// imm26 field 0x20
		add_row(2, 1, 1, 8, 32'hE000_0020, 0, 0, 0, 0, 0, 32'h0000_0020);
		// return select falls through
		add_row(3, 1, 1, 32, 32'h6000_1234, 0, 0, 0, 0, 0, 32'h0000_0080);
		add_row(3, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0084);
		// taken imm26 word loses to the redirect
		add_row(4, 1, 1, 34, 32'hE000_0030, 1, 32'h3000_0020, 0, 0, 0, 32'h0000_0088);
		// aliased imm26 keeps the top pc nibble
		add_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h3000_0020);
		add_row(4, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h3000_0080);
		add_row(4, 1, 0, 0, 0, 1, 32'h0000_0100, 0, 0, 0, 32'h3000_0084);
		// conditional branch to the self loop at 0x180
		add_row(5, 1, 1, 64, 32'h8000_1F00, 0, 0, 0, 0, 0, 32'h0000_0100);
		add_row(5, 16, 1, 96, 32'hA03F_FF00, 0, 0, 1, 32'h0000_0100, 0, 32'h0000_0180);
		add_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0180);
		add_row(5, 1, 0, 0, 0, 1, 32'h0000_0100, 0, 0, 0, 32'h0000_0180);
		// high bits still zero so taken
		add_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0100);
		add_row(5, 16, 0, 0, 0, 0, 0, 1, 32'h0000_0100, 0, 32'h0000_0180);
		add_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0180);
		add_row(5, 1, 0, 0, 0, 1, 32'h0000_0100, 0, 0, 0, 32'h0000_0180);
		// weights at 32 now predict not taken
		add_row(5, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0100);
		add_row(5, 1, 0, 0, 0, 1, 32'h0000_0180, 0, 0, 0, 32'h0000_0104);
		// 132 steps in total must clamp at the top
		add_row(6, 100, 0, 0, 0, 0, 0, 1, 32'h0000_0100, 0, 32'h0000_0180);
		add_row(6, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0180);
		add_row(6, 1, 0, 0, 0, 1, 32'h0000_0100, 0, 0, 0, 32'h0000_0180);
		add_row(6, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0100);
		add_row(6, 1, 0, 0, 0, 1, 32'h0000_0180, 0, 0, 0, 32'h0000_0104);
		// taken run fills the history with ones
		add_row(7, 8, 0, 0, 0, 0, 0, 1, 32'h0000_0100, 1, 32'h0000_0180);
		add_row(7, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0180);
		add_row(7, 1, 0, 0, 0, 1, 32'h0000_0100, 0, 0, 0, 32'h0000_0180);
		// all-ones history turns the positive weights into a taken vote
		add_row(7, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0100);
		add_row(7, 1, 0, 0, 0, 0, 0, 0, 0, 0, 32'h0000_0180);
	endtask

	task automatic preload_memory();
		row_t r;
		seed = 64581;
		// filler keeps select at 00 so it never branches
		for (int a = 0; a < `BPRED_IMEM_DEPTH; a++) begin
			image[a] = $random(seed) & 32'h3FFF_FFFF;
		end
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			if (r.pl_en) begin
				image[r.pl_addr] = r.pl_word;
			end
		end
		for (int a = 0; a < `BPRED_IMEM_DEPTH; a++) begin
			imem_wren = 1'b1;
			imem_addr = `BPRED_IMEM_ADDR_W'(a);
			imem_data = image[a];
			wait_cycles(1);
		end
		imem_wren = 1'b0;
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		row_t cur;
		row_t nxt;
		bit last_of_test;
		clk = 1'b0;
		reset = 1'b0;
		imem_wren = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		redirect = 1'b0;
		redirect_pc = '0;
		update = 1'b0;
		update_pc = '0;
		update_dir = 1'b0;
		n_checks = 0;
		n_errors = 0;
		test_checks = 0;
		test_errors = 0;
		build_table();
		wait_cycles(1);
		preload_memory();
		// weights and history start from zero after reset
		model_ghr = '0;
		pend_upd = 1'b0;
		pend_pc = '0;
		pend_dir = 1'b0;
		for (int i = 0; i < `BPRED_GHR_LEN; i++) begin
			for (int e = 0; e < `BPRED_TABLE_ENTRIES; e++) begin
				model_w[i][e] = 0;
			end
		end
		reset = 1'b1;
		wait_cycles(4);
		reset = 1'b0;
		for (int i = 0; i < rows.size(); i++) begin
			cur = rows[i];
			for (int rep = 0; rep < cur.count; rep++) begin
				check_cycle(cur.exp_pc);
				drive_row(cur);
				wait_cycles(1);
			end
			last_of_test = (i == rows.size() - 1);
			if (!last_of_test) begin
				nxt = rows[i+1];
				last_of_test = (nxt.test != cur.test);
			end
			if (last_of_test) begin
				$display("test %0d %s: %0d checks, %0d errors",
					cur.test, test_title(cur.test), test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
		end
		$display("total: %0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hdl/bpred_pkg.sv
hdl/history_if.sv
hdl/insn_mem.sv
hdl/fetch_unit.sv
hdl/history_register.sv
hdl/perceptron_lane.sv
hdl/perceptron_sum.sv
hdl/bpred_top.sv
sim/bpred_tb.sv
